//--- project.f
+incdir+verilog
verilog/cpu900_pkg.sv
verilog/cpu900_fetch.sv
verilog/cpu900_ctrl.sv
verilog/cpu900_idx.sv
verilog/cpu900_regs.sv
verilog/cpu900_core.sv
verif/cpu900_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the load slice testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module cpu900_tb \
    -o cpu900_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/cpu900_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi
exit 0

//--- verif/cpu900_tb.sv
// testbench for the 900H load slice.
// runs a table of indexed loads from memory models and checks every register.
`include "cpu900_defs.svh"

module cpu900_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROW   = 14;
    localparam int PMEM_W = 256;             // program memory in 16-bit words.
    localparam int DMEM_B = 512;             // data memory in bytes.
    localparam int NR     = 2 * `CPU900_NREG;
    localparam logic [1:0] K_LD   = 2'd0;    // prefix followed by LD R,(mem).
    localparam logic [1:0] K_BAD  = 2'd1;    // prefix followed by an unsupported opcode.
    localparam logic [1:0] K_SKIP = 2'd2;    // single word that is not a prefix.

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      cen;
    logic [`CPU900_ADDR_W-1:0] prog_addr;
    logic                      prog_rd;
    logic [`CPU900_OP_W-1:0]   prog_data;
    logic [`CPU900_ADDR_W-1:0] ram_addr;
    logic                      ram_rd;
    logic [`CPU900_REG_W-1:0]  ram_rdata;
    logic [2:0]                rd_sel;
    logic [`CPU900_REG_W-1:0]  rd_data;
    logic                      illegal;

    logic [15:0] t_pfx [NROW];     // prefix word with its byte operand on top.
    logic [15:0] t_op  [NROW];     // second opcode word.
    logic [1:0]  t_kind [NROW];
    logic        t_rep [NROW];     // row is repeated with cen dropping.
    int          t_reg [NROW];     // expected destination, filled by the model.
    logic [31:0] t_val [NROW];     // expected register value after the load.
    logic [15:0] pmem [PMEM_W];
    logic [7:0]  dmem [DMEM_B];
    logic [31:0] mdl [NR];         // model register file, index 4-7 is bank F.
    logic [15:0] pword;
    logic [31:0] dword;
    int          seed;

    cpu900_core u_dut (.clk(clk), .rst(rst), .cen(cen), .prog_addr(prog_addr),
        .prog_rd(prog_rd), .prog_data(prog_data), .ram_addr(ram_addr), .ram_rd(ram_rd),
        .ram_rdata(ram_rdata), .rd_sel(rd_sel), .rd_data(rd_data), .illegal(illegal));

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [31:0] rd_long(input int a);
        return {dmem[a + 3], dmem[a + 2], dmem[a + 1], dmem[a]};   // little-endian.
    endfunction

    // program memory answers a fetch one cen cycle later.
    always @(posedge clk) begin
        if (cen && prog_rd) begin
            if (prog_addr > 24'd510) begin
                abort_run("fetch went past the end of program memory");
            end
            pword = pmem[prog_addr[8:1]];
            #1;
            prog_data = pword;
        end
    end

    // data memory returns 32 bits from the byte address one cen cycle later.
    always @(posedge clk) begin
        if (cen && ram_rd) begin
            if (ram_addr > 24'd508) begin
                abort_run("data read went past the end of data memory");
            end
            dword = rd_long(int'(ram_addr));
            #1;
            ram_rdata = dword;
        end
    end

    task automatic put_row(input int i, input logic [15:0] p, input logic [15:0] o,
                           input logic [1:0] k, input logic rep);
        t_pfx[i]  = p;
        t_op[i]   = o;
        t_kind[i] = k;
        t_rep[i]  = rep;
    endtask

    task automatic fill_table();
        put_row(0,  16'h10E0, 16'h0024, K_LD, 1'b1);    // long from 0x10 into F0, the base.
        put_row(1,  16'h20C0, 16'h0021, K_LD, 1'b1);    // byte into E1.
        put_row(2,  16'h24D0, 16'h0021, K_LD, 1'b1);    // word over the same register.
        put_row(3,  16'h30E0, 16'h0022, K_LD, 1'b1);
        put_row(4,  16'h35C0, 16'h0022, K_LD, 1'b1);    // byte keeps the upper 24 bits.
        put_row(5,  16'h41D0, 16'h0027, K_LD, 1'b1);    // word from an odd address into F3.
        put_row(6,  16'h1234, 16'h0000, K_SKIP, 1'b0);
        put_row(7,  16'h00A4, 16'h0023, K_LD, 1'b1);    // indirect through F0.
        put_row(8,  16'h0084, 16'h0025, K_LD, 1'b1);
        put_row(9,  16'h209C, 16'h0020, K_LD, 1'b1);    // F0 plus 0x20.
        put_row(10, 16'hF0AC, 16'h0026, K_LD, 1'b1);    // F0 minus 0x10.
        put_row(11, 16'h50E0, 16'h0008, K_BAD, 1'b0);
        put_row(12, 16'h55F8, 16'h0000, K_SKIP, 1'b0);  // 11zz_1xxx is no prefix here.
        put_row(13, 16'h808C, 16'h0020, K_LD, 1'b1);    // F0 minus 0x80 reaches address 0.
    endtask

    // applies one load row to the model register file.
    task automatic model_load(input int r);
        logic [7:0]  pb;
        logic [7:0]  hb;
        logic [23:0] ea;
        logic [31:0] m;
        int          dst;
        pb = t_pfx[r][7:0];
        hb = t_pfx[r][15:8];
        if (pb[7:6] == 2'b11) begin
            ea = {16'h0000, hb};                                   // absolute byte.
        end else if (pb[3]) begin
            ea = mdl[pb[2:0]][23:0] + {{16{hb[7]}}, hb};           // signed displacement.
        end else begin
            ea = mdl[pb[2:0]][23:0];
        end
        case (pb[5:4])
            2'd0:    m = 32'h0000_00FF;
            2'd1:    m = 32'h0000_FFFF;
            default: m = 32'hFFFF_FFFF;
        endcase
        dst = int'({t_op[r][2], t_op[r][1:0]});                    // bank bit on top.
        mdl[dst] = (mdl[dst] & ~m) | (rd_long(int'(ea)) & m);
        t_reg[r] = dst;
        t_val[r] = mdl[dst];
    endtask

    task automatic run_pass(input logic rand_cen);
        int   n;
        int   nld;
        int   nbad;
        int   nskip;
        int   limit;
        int   cyc;
        int   k;
        logic wr_due;
        logic chk;
        int   ld_q[$];
        n = 0;
        nld = 0;
        nbad = 0;
        nskip = 0;
        for (int i = 0; i < NR; i++) begin
            mdl[i] = '0;                                           // registers clear on reset.
        end
        for (int r = 0; r < NROW; r++) begin
            if (!rand_cen || t_rep[r]) begin
                pmem[n] = t_pfx[r];
                n++;
                if (t_kind[r] == K_SKIP) begin
                    nskip++;
                end else begin
                    pmem[n] = t_op[r];
                    n++;
                    if (t_kind[r] == K_LD) begin
                        nld++;
                        ld_q.push_back(r);
                        model_load(r);
                    end else begin
                        nbad++;
                    end
                end
            end
        end
        for (int i = n; i < PMEM_W; i++) begin
            pmem[i] = {8'(i), 2'b01, 6'(i)};                       // never decodes as a prefix.
        end
        limit = 2 * (7 * (nld + nbad) + 2 * nskip) + 50;
        @(posedge clk);
        #1;
        rst = 1'b1;
        cen = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        cyc = 0;
        k = 0;
        wr_due = 1'b0;
        while (k < nld) begin
            @(posedge clk);
            chk = 1'b0;
            if (cen) begin
                cyc++;                                             // low cen cycles are free.
                chk = wr_due;                                      // write follows the read.
                wr_due = ram_rd;
            end
            if (cyc > limit) begin
                abort_run("timeout: program did not finish");
            end
            #1;
            cen = rand_cen ? ($random(seed) % 4 != 0) : 1'b1;
            if (chk) begin
                rd_sel = 3'(t_reg[ld_q[k]]);
                #1;
                check_eq($sformatf("rd_data[%0d]", t_reg[ld_q[k]]), rd_data, t_val[ld_q[k]]);
                k++;
            end
        end
        for (int r = 0; r < NR; r++) begin
            @(posedge clk);
            #1;
            cen = 1'b0;                                            // hold the core still.
            rd_sel = 3'(r);
            #1;
            check_eq($sformatf("rd_data[%0d]", r), rd_data, mdl[r]);
        end
        check_eq("illegal", {31'b0, illegal}, {31'b0, nbad != 0});
    endtask

    initial begin
        rst = 1'b1;
        cen = 1'b1;
        prog_data = '0;
        ram_rdata = '0;
        rd_sel = '0;
        seed = 51;
        fill_table();
        for (int i = 0; i < DMEM_B; i++) begin
            dmem[i] = 8'($random(seed));
        end
        dmem[16] = 8'h80;                                          // base pointer 0x80 at 0x10.
        dmem[17] = 8'h00;
        dmem[18] = 8'h00;
        dmem[19] = 8'h00;
        run_pass(1'b0);
        run_pass(1'b1);                                            // loads again with cen dropping.
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- verilog/cpu900_core.sv
// top level of the 900H load slice.
// ties fetch, sequencer, address unit and registers to the two memory ports.
`include "cpu900_defs.svh"

module cpu900_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    output logic [`CPU900_ADDR_W-1:0] prog_addr,
    output logic                      prog_rd,
    input  logic [`CPU900_OP_W-1:0]   prog_data,
    output logic [`CPU900_ADDR_W-1:0] ram_addr,
    output logic                      ram_rd,
    input  logic [`CPU900_REG_W-1:0]  ram_rdata,
    input  logic [2:0]                rd_sel,
    output logic [`CPU900_REG_W-1:0]  rd_data,
    output logic                      illegal
);

    logic [`CPU900_OP_W-1:0]   cur_op;
    logic                      op_ok;
    logic                      idx_en;
    logic                      idx_ok;
    logic                      ldram_en;
    cpu900_pkg::op_size_e      regs_we;
    logic [7:0]                regs_dst;
    logic [2:0]                base_sel;
    logic [`CPU900_REG_W-1:0]  base_val;
    logic [`CPU900_ADDR_W-1:0] ea;

    cpu900_fetch u_fetch (.clk(clk), .rst(rst), .cen(cen), .idx_en(idx_en),
        .ldram_en(ldram_en), .prog_addr(prog_addr), .prog_rd(prog_rd),
        .prog_data(prog_data), .cur_op(cur_op), .op_ok(op_ok));

    cpu900_ctrl u_ctrl (.clk(clk), .rst(rst), .cen(cen), .cur_op(cur_op), .op_ok(op_ok),
        .idx_en(idx_en), .idx_ok(idx_ok), .ldram_en(ldram_en), .regs_we(regs_we),
        .regs_dst(regs_dst), .illegal(illegal));

    cpu900_idx u_idx (.clk(clk), .rst(rst), .cen(cen), .cur_op(cur_op), .op_ok(op_ok),
        .idx_en(idx_en), .base_sel(base_sel), .base_val(base_val), .ea(ea),
        .idx_ok(idx_ok));

    cpu900_regs u_regs (.clk(clk), .rst(rst), .cen(cen), .ldram_en(ldram_en),
        .regs_we(regs_we), .regs_dst(regs_dst), .ea(ea), .ram_addr(ram_addr),
        .ram_rd(ram_rd), .ram_rdata(ram_rdata), .base_sel(base_sel),
        .base_val(base_val), .rd_sel(rd_sel), .rd_data(rd_data));

endmodule

//--- verilog/cpu900_ctrl.sv
// instruction sequencer for the 900H load slice.
// walks through fetch, index and RAM load phases and flags bad operands.
`include "cpu900_defs.svh"

module cpu900_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [`CPU900_OP_W-1:0] cur_op,
    input  logic                    op_ok,
    output logic                    idx_en,
    input  logic                    idx_ok,
    output logic                    ldram_en,
    output cpu900_pkg::op_size_e    regs_we,
    output logic [7:0]              regs_dst,
    output logic                    illegal
);

    localparam logic [1:0] FETCH  = 2'd0;
    localparam logic [1:0] IDX    = 2'd1;
    localparam logic [1:0] LD_RAM = 2'd2;
    localparam logic [4:0] LD_CODE = 5'b00100; // LD R,(mem).

    logic [1:0]           op_phase;
    cpu900_pkg::op_byte_u op_byte;
    cpu900_pkg::op_size_e last_size;   // operand size taken from the prefix.
    logic                 is_prefix;

    assign op_byte = cur_op[7:0];

    // 10zz_xrrr is register based and 11zz_0xxx is absolute.
    assign is_prefix = (op_byte.pfx.kind == 2'b10) ||
                       (op_byte.pfx.kind == 2'b11 && !op_byte.pfx.mode);

    function automatic cpu900_pkg::op_size_e size_of(input logic [1:0] zz);
        case (zz)
            2'd0:    size_of = cpu900_pkg::SZ_BYTE;
            2'd1:    size_of = cpu900_pkg::SZ_WORD;
            default: size_of = cpu900_pkg::SZ_LONG; // zz of 3 is treated as long.
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_phase <= FETCH;
            idx_en   <= 1'b0;
            ldram_en <= 1'b0;
            illegal  <= 1'b0;
        end else if (cen) begin
            case (op_phase)
                FETCH: begin
                    if (op_ok && is_prefix) begin
                        op_phase <= IDX;   // other first bytes are skipped.
                        idx_en   <= 1'b1;
                    end
                end
                IDX: begin
                    if (idx_ok) begin
                        idx_en <= 1'b0;
                        if (op_byte.ld.code == LD_CODE) begin
                            op_phase <= LD_RAM;
                            ldram_en <= 1'b1;
                        end else begin
                            op_phase <= FETCH; // unsupported operand.
                            illegal  <= 1'b1;  // stays set until reset.
                        end
                    end
                end
                default: begin
                    op_phase <= FETCH; // the load strobe lasts one cycle.
                    ldram_en <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (op_phase == FETCH && op_ok && is_prefix) begin
                last_size <= size_of(op_byte.pfx.size);
            end
            if (op_phase == IDX && idx_ok) begin
                regs_we  <= last_size;
                regs_dst <= {op_byte.ld.bnk ? `CPU900_BANK_CUR : `CPU900_BANK_PRV,
                             op_byte.ld.rn, 2'b00};
            end
        end
    end

    // indexing and the RAM load never overlap.
    a_idx_ld_excl: assert property (@(posedge clk) disable iff (rst)
        !(idx_en && ldram_en));

    a_ldram_pulse: assert property (@(posedge clk) disable iff (rst)
        cen && ldram_en |=> !ldram_en);

endmodule

//--- verilog/cpu900_defs.svh
// shared constants for the 900H load slice.
// widths, register-space bank nibbles and memory timing.
`ifndef CPU900_DEFS_SVH
`define CPU900_DEFS_SVH

// byte address width of both program and data memory.
`define CPU900_ADDR_W 24

// instruction words arrive 16 bits at a time.
`define CPU900_OP_W 16

// general purpose registers are 32 bits wide.
`define CPU900_REG_W 32

// high nibble of a register-space byte address for the current bank.
`define CPU900_BANK_CUR 4'hF

// high nibble of a register-space byte address for the previous bank.
`define CPU900_BANK_PRV 4'hE

// registers in each bank. Two banks make eight in total.
`define CPU900_NREG 4

// read latency of the memories in cen cycles.
`define CPU900_MEM_LAT 1

`endif

//--- verilog/cpu900_fetch.sv
// instruction fetch for the 900H load slice.
// reads one 16-bit word every two cycles and holds while an instruction runs.
`include "cpu900_defs.svh"

module cpu900_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  logic                      idx_en,
    input  logic                      ldram_en,
    output logic [`CPU900_ADDR_W-1:0] prog_addr,
    output logic                      prog_rd,
    input  logic [`CPU900_OP_W-1:0]   prog_data,
    output logic [`CPU900_OP_W-1:0]   cur_op,
    output logic                      op_ok
);

    localparam logic [`CPU900_ADDR_W-1:0] PC_STEP = 2; // two bytes per word.

    logic [`CPU900_ADDR_W-1:0] pc;
    logic [`CPU900_OP_W-1:0]   op_hold;     // last word seen, kept after op_ok.
    logic                      opnd_done;   // operand word already fetched.
    logic                      hold;
    logic                      start;

    // only the operand word may pass while indexing is active.
    assign hold  = ldram_en || (idx_en && (opnd_done || op_ok));
    assign start = !prog_rd && !hold;   // request and latch cycles alternate.

    assign prog_addr = pc;
    assign cur_op    = op_ok ? prog_data : op_hold;   // the sequencer reads it late.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= '0;
            prog_rd   <= 1'b0;
            op_ok     <= 1'b0;
            opnd_done <= 1'b0;
        end else if (cen) begin
            prog_rd <= start;
            op_ok   <= prog_rd;    // data comes back one cycle after the read.
            if (prog_rd) begin
                pc <= pc + PC_STEP;
            end
            if (!idx_en) begin
                opnd_done <= 1'b0; // a new instruction may start.
            end else if (op_ok) begin
                opnd_done <= 1'b1; // the operand has arrived.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && op_ok) begin
            op_hold <= prog_data;
        end
    end

    // a word is delivered for one cen cycle only.
    a_op_ok_pulse: assert property (@(posedge clk) disable iff (rst)
        cen && op_ok |=> !op_ok);

endmodule

//--- verilog/cpu900_idx.sv
// effective address unit for the 900H load slice.
// forms the data address from a base register, a displacement or an absolute byte.
`include "cpu900_defs.svh"

module cpu900_idx (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  logic [`CPU900_OP_W-1:0]   cur_op,
    input  logic                      op_ok,
    input  logic                      idx_en,
    output logic [2:0]                base_sel,
    input  logic [`CPU900_REG_W-1:0]  base_val,
    output logic [`CPU900_ADDR_W-1:0] ea,
    output logic                      idx_ok
);

    logic [`CPU900_OP_W-1:0]   pfx_q;      // prefix word with the byte operand on top.
    cpu900_pkg::op_byte_u      pfx_byte;
    logic [`CPU900_ADDR_W-1:0] base_a;
    logic [`CPU900_ADDR_W-1:0] disp_a;
    logic [`CPU900_ADDR_W-1:0] abs_a;
    logic [`CPU900_ADDR_W-1:0] ea_nxt;
    logic                      ea_vld;     // ea holds the address for this prefix.
    logic                      opnd_seen;  // second word came before ea was ready.

    assign pfx_byte = pfx_q[7:0];
    assign base_sel = pfx_byte.pfx.rn;
    assign base_a   = base_val[`CPU900_ADDR_W-1:0];   // addresses use the low 24 bits.
    assign disp_a   = {{(`CPU900_ADDR_W-8){pfx_q[15]}}, pfx_q[15:8]};
    assign abs_a    = {{(`CPU900_ADDR_W-8){1'b0}}, pfx_q[15:8]};

    always_comb begin
        if (pfx_byte.pfx.kind == 2'b11) begin
            ea_nxt = abs_a;               // 8-bit absolute.
        end else if (pfx_byte.pfx.mode) begin
            ea_nxt = base_a + disp_a;     // base plus signed displacement.
        end else begin
            ea_nxt = base_a;              // register indirect.
        end
    end

    // pulses once when both the address and the operand word are in.
    assign idx_ok = idx_en && ea_vld && (op_ok || opnd_seen);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ea_vld    <= 1'b0;
            opnd_seen <= 1'b0;
        end else if (cen) begin
            ea_vld    <= idx_en;   // one cycle after the prefix for the base read.
            opnd_seen <= idx_en && (opnd_seen || op_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (op_ok && !idx_en) begin
                pfx_q <= cur_op;   // any word seen in the fetch phase may be a prefix.
            end
            if (idx_en) begin
                ea <= ea_nxt;
            end
        end
    end

endmodule

//--- verilog/cpu900_pkg.sv
// types shared by the 900H load slice.
// the opcode byte union and the load size encoding.
package cpu900_pkg;

    // load size, as carried on regs_we from the sequencer to the register file.
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,     // low 8 bits replaced.
        SZ_WORD = 2'd1,     // low 16 bits replaced.
        SZ_LONG = 2'd2      // whole register replaced.
    } op_size_e;

    // low byte of an instruction word. A prefix and a load opcode
    // split the same eight bits in different ways.
    typedef union packed {
        struct packed {
            logic [1:0] kind;   // 10 is register based, 11 is absolute.
            logic [1:0] size;   // zz field with the operand size.
            logic       mode;   // 1 adds the displacement in the high byte.
            logic [2:0] rn;     // base register with the bank in the top bit.
        } pfx;
        struct packed {
            logic [4:0] code;   // 00100 is LD R,(mem).
            logic       bnk;    // 1 selects the current bank.
            logic [1:0] rn;     // destination register in the bank.
        } ld;
    } op_byte_u;

endpackage

//--- verilog/cpu900_regs.sv
// register file for the 900H load slice.
// two banks of four 32-bit registers, loaded from data memory by size.
`include "cpu900_defs.svh"

module cpu900_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  logic                      ldram_en,
    input  cpu900_pkg::op_size_e      regs_we,
    input  logic [7:0]                regs_dst,
    input  logic [`CPU900_ADDR_W-1:0] ea,
    output logic [`CPU900_ADDR_W-1:0] ram_addr,
    output logic                      ram_rd,
    input  logic [`CPU900_REG_W-1:0]  ram_rdata,
    input  logic [2:0]                base_sel,
    output logic [`CPU900_REG_W-1:0]  base_val,
    input  logic [2:0]                rd_sel,
    output logic [`CPU900_REG_W-1:0]  rd_data
);

    localparam int NR = 2 * `CPU900_NREG;

    logic [`CPU900_REG_W-1:0]  rf [NR];    // index 0-3 is bank E, 4-7 is bank F.
    cpu900_pkg::op_size_e      wr_size;
    logic [2:0]                wr_idx;
    logic [`CPU900_MEM_LAT-1:0] rd_pipe;   // tracks the read until data returns.

    assign base_val = rf[base_sel];
    assign rd_data  = rf[rd_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_rd  <= 1'b0;
            rd_pipe <= '0;
            for (int i = 0; i < NR; i++) begin
                rf[i] <= '0;
            end
        end else if (cen) begin
            ram_rd  <= ldram_en;   // read in the cycle after the load strobe.
            rd_pipe <= (rd_pipe << 1) | `CPU900_MEM_LAT'(ram_rd);
            if (rd_pipe[`CPU900_MEM_LAT-1]) begin
                case (wr_size)
                    cpu900_pkg::SZ_BYTE: rf[wr_idx][7:0]  <= ram_rdata[7:0];
                    cpu900_pkg::SZ_WORD: rf[wr_idx][15:0] <= ram_rdata[15:0];
                    default:             rf[wr_idx]       <= ram_rdata;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && ldram_en) begin
            ram_addr <= ea;
            wr_size  <= regs_we;
            wr_idx   <= {regs_dst[7:4] == `CPU900_BANK_CUR, regs_dst[3:2]};
        end
    end

endmodule
